/* hw/periph_pkg.sv */
/*
 * peripheral package
 * address map, register offsets, widths and timing constants shared by
 * the APB decoder, the machine timer and the UART transmitter
 */

package periph_pkg;

	// ------------------------------------------------------------------------
	// APB layer
	localparam int APB_AW = 16;
	localparam int APB_DW = 32;

	// peripheral select field of paddr
	localparam int SLOT_MSB = 15;
	localparam int SLOT_LSB = 12;

	localparam logic [SLOT_MSB-SLOT_LSB:0] SLOT_TIMER = 4'd0;
	localparam logic [SLOT_MSB-SLOT_LSB:0] SLOT_UART  = 4'd1;

	// ------------------------------------------------------------------------
	// timebase
	localparam int CLK_MHZ = 4;
	localparam int TICK_CW = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

	// timer registers, offsets within the slot
	localparam logic [APB_AW-1:0] TMR_CTRL     = 16'h0000;
	localparam logic [APB_AW-1:0] TMR_MTIME_LO = 16'h0008;
	localparam logic [APB_AW-1:0] TMR_MTIME_HI = 16'h000c;
	localparam logic [APB_AW-1:0] TMR_CMP_LO   = 16'h0010;
	localparam logic [APB_AW-1:0] TMR_CMP_HI   = 16'h0014;

	// ------------------------------------------------------------------------
	// UART transmitter
	localparam logic [APB_AW-1:0] UART_CSR    = 16'h0000;
	localparam logic [APB_AW-1:0] UART_TXDATA = 16'h0004;
	localparam logic [APB_AW-1:0] UART_DIV    = 16'h0008;

	// clocks per bit out of reset
	localparam int UART_DIV_RESET = 16;
	localparam int UART_DIV_W     = 16;

	localparam int TXFIFO_DEPTH = 4;

	typedef logic [7:0]        byte_t;
	typedef logic [APB_DW-1:0] word_t;

endpackage

/* hw/apb_if.sv */
/*
 * APB interface
 * requester drives the select, enable, direction, address and write data;
 * the completer answers with read data, ready and error
 */

`timescale 1ns/1ps

interface apb_if;

	logic                          psel;
	logic                          penable;
	logic                          pwrite;
	logic [periph_pkg::APB_AW-1:0] paddr;
	periph_pkg::word_t             pwdata;
	periph_pkg::word_t             prdata;
	logic                          pready;
	logic                          pslverr;

	modport master (
		output psel, penable, pwrite, paddr, pwdata,
		input  prdata, pready, pslverr
	);

	modport slave (
		input  psel, penable, pwrite, paddr, pwdata,
		output prdata, pready, pslverr
	);

endinterface

/* hw/apb_decoder.sv */
/*
 * APB address decoder
 * splits one APB port into the timer and UART slots by the high address
 * bits and answers unmapped slots itself with an error
 */

`timescale 1ns/1ps

module apb_decoder (
	apb_if.slave  s_apb,
	apb_if.master m_timer,
	apb_if.master m_uart
);

	localparam int SLOT_W = periph_pkg::SLOT_MSB - periph_pkg::SLOT_LSB + 1;
	localparam int OFFS_W = periph_pkg::SLOT_LSB;

	logic [SLOT_W-1:0]                 slot;
	logic                              hit_timer;
	logic                              hit_uart;
	logic [periph_pkg::APB_AW-1:0]     offset;

	assign slot      = s_apb.paddr[periph_pkg::SLOT_MSB:periph_pkg::SLOT_LSB];
	assign hit_timer = (slot == periph_pkg::SLOT_TIMER);
	assign hit_uart  = (slot == periph_pkg::SLOT_UART);

	// peripherals only ever see the offset within their slot
	assign offset = {{(periph_pkg::APB_AW - OFFS_W){1'b0}}, s_apb.paddr[OFFS_W-1:0]};

	// ------------------------------------------------------------------------
	// request fan-out

	assign m_timer.psel    = s_apb.psel & hit_timer;
	assign m_timer.penable = s_apb.penable & hit_timer;
	assign m_timer.pwrite  = s_apb.pwrite;
	assign m_timer.paddr   = offset;
	assign m_timer.pwdata  = s_apb.pwdata;

	assign m_uart.psel     = s_apb.psel & hit_uart;
	assign m_uart.penable  = s_apb.penable & hit_uart;
	assign m_uart.pwrite   = s_apb.pwrite;
	assign m_uart.paddr    = offset;
	assign m_uart.pwdata   = s_apb.pwdata;

	// ------------------------------------------------------------------------
	// response mux

	always_comb begin
		s_apb.prdata  = '0;
		s_apb.pready  = 1'b0;
		s_apb.pslverr = 1'b0;
		if (s_apb.psel) begin
			if (hit_timer) begin
				s_apb.prdata  = m_timer.prdata;
				s_apb.pready  = m_timer.pready;
				s_apb.pslverr = m_timer.pslverr;
			end else if (hit_uart) begin
				s_apb.prdata  = m_uart.prdata;
				s_apb.pready  = m_uart.pready;
				s_apb.pslverr = m_uart.pslverr;
			end else begin
				// nothing behind this slot
				s_apb.pready  = 1'b1;
				s_apb.pslverr = 1'b1;
			end
		end
	end

endmodule

/* hw/mtimer.sv */
/*
 * RISC-V machine timer
 * microsecond prescaler, 64-bit mtime and mtimecmp as 32-bit APB halves,
 * registered timer interrupt, count stalls while the hart is halted
 */

`timescale 1ns/1ps

module mtimer (
	input  logic  clk,
	input  logic  rst_n,
	apb_if.slave  s_apb,
	input  logic  i_dbg_halt,
	output logic  o_timer_irq
);

	localparam int DW = periph_pkg::APB_DW;

	logic [periph_pkg::TICK_CW-1:0] tick_ctr;
	logic                           tick;

	logic        ctrl_en;
	logic [63:0] mtime;
	logic [63:0] mtimecmp;
	logic        wr_en;
	logic        count_en;

	// ------------------------------------------------------------------------
	// microsecond timebase

	// counts down, pulse registered on the wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= '0;
			tick     <= 1'b0;
		end else begin
			if (|tick_ctr) begin
				tick_ctr <= tick_ctr - 1'b1;
			end else begin
				tick_ctr <= periph_pkg::TICK_CW'(periph_pkg::CLK_MHZ - 1);
			end
			tick <= ~|tick_ctr;
		end
	end

	// ------------------------------------------------------------------------
	// register writes

	assign wr_en    = s_apb.psel & s_apb.penable & s_apb.pwrite;
	assign count_en = tick & ctrl_en & ~i_dbg_halt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b0;
		end else if (wr_en && s_apb.paddr == periph_pkg::TMR_CTRL) begin
			ctrl_en <= s_apb.pwdata[0];
		end
	end

	// a software write wins over the tick in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_en && s_apb.paddr == periph_pkg::TMR_MTIME_LO) begin
			mtime[DW-1:0] <= s_apb.pwdata;
		end else if (wr_en && s_apb.paddr == periph_pkg::TMR_MTIME_HI) begin
			mtime[63:DW] <= s_apb.pwdata;
		end else if (count_en) begin
			mtime <= mtime + 64'd1;
		end
	end

	// all ones out of reset keeps the interrupt quiet
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else if (wr_en && s_apb.paddr == periph_pkg::TMR_CMP_LO) begin
			mtimecmp[DW-1:0] <= s_apb.pwdata;
		end else if (wr_en && s_apb.paddr == periph_pkg::TMR_CMP_HI) begin
			mtimecmp[63:DW] <= s_apb.pwdata;
		end
	end

	// ------------------------------------------------------------------------
	// interrupt

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_timer_irq <= 1'b0;
		end else begin
			o_timer_irq <= (mtime >= mtimecmp);
		end
	end

	// ------------------------------------------------------------------------
	// read path, always ready, no error

	always_comb begin
		case (s_apb.paddr)
			periph_pkg::TMR_CTRL:     s_apb.prdata = {{(DW - 1){1'b0}}, ctrl_en};
			periph_pkg::TMR_MTIME_LO: s_apb.prdata = mtime[DW-1:0];
			periph_pkg::TMR_MTIME_HI: s_apb.prdata = mtime[63:DW];
			periph_pkg::TMR_CMP_LO:   s_apb.prdata = mtimecmp[DW-1:0];
			periph_pkg::TMR_CMP_HI:   s_apb.prdata = mtimecmp[63:DW];
			default:                  s_apb.prdata = '0;
		endcase
	end

	assign s_apb.pready  = 1'b1;
	assign s_apb.pslverr = 1'b0;

endmodule

/* hw/uart_tx.sv */
/*
 * UART transmitter
 * divisor register, small byte FIFO and 8N1 serializer;
 * a TXDATA write stalls on pready while the FIFO is full
 */

`timescale 1ns/1ps

module uart_tx (
	input  logic  clk,
	input  logic  rst_n,
	apb_if.slave  s_apb,
	output logic  o_uart_tx
);

	localparam int DEPTH = periph_pkg::TXFIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int DIV_W = periph_pkg::UART_DIV_W;

	logic [DIV_W-1:0]       div;
	periph_pkg::byte_t      mem [DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [PTR_W:0]         level;
	logic                   fifo_full;
	logic                   fifo_empty;
	logic                   txdata_wr;
	logic                   push;
	logic                   pop;

	logic                   tx_busy;
	logic [9:0]             shifter;
	logic [3:0]             bits_left;
	logic [DIV_W-1:0]       bit_ctr;
	logic                   frame_end;

	assign fifo_full  = (level == (PTR_W + 1)'(DEPTH));
	assign fifo_empty = (level == '0);

	// ------------------------------------------------------------------------
	// APB side

	assign txdata_wr = s_apb.psel & s_apb.pwrite & (s_apb.paddr == periph_pkg::UART_TXDATA);

	// a pop in the same cycle frees the slot for the stalled write
	assign push = txdata_wr & s_apb.penable & (~fifo_full | pop);

	assign s_apb.pready  = ~(txdata_wr & fifo_full & ~pop);
	assign s_apb.pslverr = 1'b0;

	always_comb begin
		case (s_apb.paddr)
			periph_pkg::UART_CSR: begin
				s_apb.prdata = {{(periph_pkg::APB_DW - 2){1'b0}}, fifo_full,
					tx_busy | ~fifo_empty};
			end
			periph_pkg::UART_DIV: s_apb.prdata = {{(periph_pkg::APB_DW - DIV_W){1'b0}}, div};
			default:              s_apb.prdata = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div <= DIV_W'(periph_pkg::UART_DIV_RESET);
		end else if (s_apb.psel && s_apb.penable && s_apb.pwrite &&
				s_apb.paddr == periph_pkg::UART_DIV) begin
			div <= s_apb.pwdata[DIV_W-1:0];
		end
	end

	// ------------------------------------------------------------------------
	// byte FIFO

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= periph_pkg::byte_t'(s_apb.pwdata[7:0]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// serializer

	// last cycle of the stop bit
	assign frame_end = tx_busy & (bit_ctr == '0) & (bits_left == '0);

	// next frame starts right behind the stop bit
	assign pop = ~fifo_empty & (~tx_busy | frame_end);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy   <= 1'b0;
			shifter   <= '1;
			bits_left <= '0;
			bit_ctr   <= '0;
		end else if (pop) begin
			tx_busy   <= 1'b1;
			shifter   <= {1'b1, mem[rd_ptr], 1'b0};
			bits_left <= 4'd9;
			bit_ctr   <= div - 1'b1;
		end else if (tx_busy) begin
			if (bit_ctr == '0) begin
				// shift ones in so the line idles high
				shifter <= {1'b1, shifter[9:1]};
				bit_ctr <= div - 1'b1;
				if (bits_left == '0) begin
					tx_busy <= 1'b0;
				end else begin
					bits_left <= bits_left - 1'b1;
				end
			end else begin
				bit_ctr <= bit_ctr - 1'b1;
			end
		end
	end

	assign o_uart_tx = shifter[0];

endmodule

/* hw/periph_top.sv */
/*
 * peripheral subsystem top level
 * APB slave port in front of an address decoder, the RISC-V machine
 * timer and the UART transmitter
 */

`timescale 1ns/1ps

module periph_top (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          i_psel,
	input  logic                          i_penable,
	input  logic                          i_pwrite,
	input  logic [periph_pkg::APB_AW-1:0] i_paddr,
	input  periph_pkg::word_t             i_pwdata,
	output periph_pkg::word_t             o_prdata,
	output logic                          o_pready,
	output logic                          o_pslverr,

	input  logic                          i_dbg_halt,
	output logic                          o_timer_irq,
	output logic                          o_uart_tx
);

	apb_if host_apb ();
	apb_if timer_apb ();
	apb_if uart_apb ();

	// host side port mapping
	assign host_apb.psel    = i_psel;
	assign host_apb.penable = i_penable;
	assign host_apb.pwrite  = i_pwrite;
	assign host_apb.paddr   = i_paddr;
	assign host_apb.pwdata  = i_pwdata;
	assign o_prdata         = host_apb.prdata;
	assign o_pready         = host_apb.pready;
	assign o_pslverr        = host_apb.pslverr;

	apb_decoder u_apb_decoder (
		.s_apb   (host_apb.slave),
		.m_timer (timer_apb.master),
		.m_uart  (uart_apb.master)
	);

	mtimer u_mtimer (
		.clk         (clk),
		.rst_n       (rst_n),
		.s_apb       (timer_apb.slave),
		.i_dbg_halt  (i_dbg_halt),
		.o_timer_irq (o_timer_irq)
	);

	uart_tx u_uart_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.s_apb     (uart_apb.slave),
		.o_uart_tx (o_uart_tx)
	);

endmodule

/* test/periph_assertions.sv */
/*
 * APB and serial line checks
 * concurrent properties on one APB port and the UART line, bound into
 * the top level for the decoder host port and the UART port
 */

`timescale 1ns/1ps

module periph_assertions (
	input logic                          clk,
	input logic                          rst_n,
	input logic                          psel,
	input logic                          penable,
	input logic [periph_pkg::APB_AW-1:0] paddr,
	input logic                          pready,
	input logic                          uart_tx
);

	// access phase only ever follows a select
	penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(penable) |-> psel)
		else $error("penable rose without psel");

	// address held through wait states
	paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && !pready) |=> $stable(paddr))
		else $error("paddr changed while pready was low");

	line_idle_in_reset: assert property (@(posedge clk) !rst_n |-> uart_tx)
		else $error("serial line low during reset");

endmodule

// host side of the decoder, clocked from the top level
bind periph_top periph_assertions host_side_checks (
	.clk(clk), .rst_n(rst_n), .psel(host_apb.psel), .penable(host_apb.penable),
	.paddr(host_apb.paddr), .pready(host_apb.pready), .uart_tx(o_uart_tx)
);

// port in front of the UART transmitter
bind periph_top periph_assertions uart_side_checks (
	.clk(clk), .rst_n(rst_n), .psel(uart_apb.psel), .penable(uart_apb.penable),
	.paddr(uart_apb.paddr), .pready(uart_apb.pready), .uart_tx(o_uart_tx)
);

/* test/tb_periph.sv */
/*
 * peripheral subsystem testbench
 * seeded random APB traffic to the timer and UART, checked against
 * register, timebase, interrupt and serial receiver models
 */

`timescale 1ns/1ps

module tb_periph;

	localparam int TIMEOUT = 2000;

	logic                          clk = 1'b0;
	logic                          rst_n;
	logic                          i_psel;
	logic                          i_penable;
	logic                          i_pwrite;
	logic [periph_pkg::APB_AW-1:0] i_paddr;
	periph_pkg::word_t             i_pwdata;
	periph_pkg::word_t             o_prdata;
	logic                          o_pready;
	logic                          o_pslverr;
	logic                          i_dbg_halt;
	logic                          o_timer_irq;
	logic                          o_uart_tx;

	string             cur_test;
	int                test_errs;
	int                tests_run;
	int                tests_failed;
	int                total_errs;
	int                uart_div = periph_pkg::UART_DIV_RESET;
	periph_pkg::byte_t rx_q[$];
	logic              mon_busy;
	int                mon_ticks;
	int                mon_bit;
	periph_pkg::byte_t mon_byte;

	always #4 clk = ~clk;

	periph_top i_dut (.*);

	// ------------------------------------------------------------------------
	// bookkeeping

	task automatic check_value(input string what, input periph_pkg::word_t expected,
			input periph_pkg::word_t actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s (%s): expected %h, actual %h", cur_test, what,
				expected, actual);
			test_errs++;
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		assert (cond) else begin
			$display("ERROR in %s: %s", cur_test, what);
			test_errs++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs != 0) begin
			tests_failed++;
		end
		$display("test %s: %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "fail",
			test_errs);
	endtask

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// ------------------------------------------------------------------------
	// APB master driven 1 ns after a rising edge

	task automatic apb_xfer(input logic wr, input logic [3:0] slot,
			input logic [periph_pkg::APB_AW-1:0] offs, input periph_pkg::word_t wdata,
			output periph_pkg::word_t rdata, output logic err, output int stalls);
		i_psel    = 1'b1;
		i_penable = 1'b0;
		i_pwrite  = wr;
		i_paddr   = {slot, offs[periph_pkg::SLOT_LSB-1:0]};
		i_pwdata  = wdata;
		wait_cycles(1);
		i_penable = 1'b1;
		stalls    = 0;
		@(negedge clk);
		while (!o_pready) begin
			stalls++;
			if (stalls > TIMEOUT) begin
				abort_run("APB transfer never completed");
			end
			@(negedge clk);
		end
		rdata = o_prdata;
		err   = o_pslverr;
		wait_cycles(1);
		i_psel    = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] slot, input logic [15:0] offs,
			input periph_pkg::word_t data);
		periph_pkg::word_t rd;
		logic              err;
		int                stalls;
		apb_xfer(1'b1, slot, offs, data, rd, err, stalls);
		check_true("pslverr on a mapped write", !err);
	endtask

	task automatic apb_read(input logic [3:0] slot, input logic [15:0] offs,
			output periph_pkg::word_t data);
		logic err;
		int   stalls;
		apb_xfer(1'b0, slot, offs, '0, data, err, stalls);
		check_true("pslverr on a mapped read", !err);
	endtask

	task automatic write_readback(input string what, input logic [3:0] slot,
			input logic [15:0] offs, input periph_pkg::word_t data,
			input periph_pkg::word_t expected);
		periph_pkg::word_t rd;
		apb_write(slot, offs, data);
		apb_read(slot, offs, rd);
		check_value(what, expected, rd);
	endtask

	task automatic wait_irq(input logic level, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (o_timer_irq !== level && cycles < limit) begin
			wait_cycles(1);
			cycles++;
		end
		check_true(what, o_timer_irq === level);
	endtask

	// ------------------------------------------------------------------------
	// serial receiver sampling each bit in its middle

	always @(negedge clk) begin
		if (!rst_n) begin
			mon_busy = 1'b0;
		end else if (!mon_busy) begin
			mon_busy  = ~o_uart_tx;
			mon_ticks = 0;
			mon_bit   = 0;
		end else begin
			mon_ticks++;
			if (mon_ticks == uart_div / 2 + mon_bit * uart_div) begin
				if (mon_bit == 0) begin
					check_value("start bit", '0, {31'b0, o_uart_tx});
				end else if (mon_bit < 9) begin
					mon_byte = {o_uart_tx, mon_byte[7:1]};
				end else begin
					check_value("stop bit", 32'd1, {31'b0, o_uart_tx});
					rx_q.push_back(mon_byte);
					mon_busy = 1'b0;
				end
				mon_bit++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// test sequence

	initial begin
		periph_pkg::word_t rd;
		periph_pkg::word_t t0;
		periph_pkg::word_t wv;
		periph_pkg::word_t step;
		periph_pkg::byte_t exp_q[$];
		logic              err;
		int                n;
		int                stalls;
		int                total_stalls;

		i_psel     = 1'b0;
		i_penable  = 1'b0;
		i_pwrite   = 1'b0;
		i_paddr    = '0;
		i_pwdata   = '0;
		i_dbg_halt = 1'b0;
		rst_n      = 1'b1;
		// seeds the generator for the whole run
		wv = $urandom(32'h726b_bcd8);
		#1;
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		wait_cycles(2);

		start_test("registers");
		wv = $urandom;
		write_readback("mtimecmp lo", periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP_LO, wv, wv);
		wv = $urandom;
		write_readback("mtimecmp hi", periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP_HI, wv, wv);
		wv = $urandom;
		write_readback("uart div", periph_pkg::SLOT_UART, periph_pkg::UART_DIV, wv,
			{16'b0, wv[15:0]});
		wv = $urandom;
		write_readback("ctrl", periph_pkg::SLOT_TIMER, periph_pkg::TMR_CTRL, wv, {31'b0, wv[0]});
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CTRL, '0);
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP_HI, '1);
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP_LO, '1);
		end_test();

		start_test("unmapped");
		repeat (3) begin
			n  = $urandom_range(15, 2);
			wv = $urandom;
			apb_xfer(1'b1, 4'(n), {4'b0, wv[11:2], 2'b00}, wv, rd, err, stalls);
			check_value("write pslverr", 32'd1, {31'b0, err});
			apb_xfer(1'b0, 4'(n), {4'b0, wv[11:2], 2'b00}, '0, rd, err, stalls);
			check_value("read pslverr", 32'd1, {31'b0, err});
			check_value("read data", '0, rd);
		end
		apb_read(periph_pkg::SLOT_UART, periph_pkg::UART_CSR, rd);
		end_test();

		start_test("timebase");
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CTRL, 32'd1);
		apb_read(periph_pkg::SLOT_TIMER, periph_pkg::TMR_MTIME_LO, t0);
		n = $urandom_range(40, 5);
		wait_cycles(n * periph_pkg::CLK_MHZ);
		apb_read(periph_pkg::SLOT_TIMER, periph_pkg::TMR_MTIME_LO, rd);
		step = rd - t0;
		assert (step + 1 >= n && step <= n + 1) else begin
			$display("CHECK FAILED %s (mtime step): expected %0d +-1, actual %0d", cur_test,
				n, step);
			test_errs++;
		end
		i_dbg_halt = 1'b1;
		apb_read(periph_pkg::SLOT_TIMER, periph_pkg::TMR_MTIME_LO, t0);
		wait_cycles(n * periph_pkg::CLK_MHZ);
		apb_read(periph_pkg::SLOT_TIMER, periph_pkg::TMR_MTIME_LO, rd);
		check_value("mtime while halted", t0, rd);
		i_dbg_halt = 1'b0;
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CTRL, '0);
		apb_read(periph_pkg::SLOT_TIMER, periph_pkg::TMR_MTIME_LO, t0);
		wait_cycles(n * periph_pkg::CLK_MHZ);
		apb_read(periph_pkg::SLOT_TIMER, periph_pkg::TMR_MTIME_LO, rd);
		check_value("mtime while disabled", t0, rd);
		end_test();

		start_test("interrupt");
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CTRL, 32'd1);
		apb_read(periph_pkg::SLOT_TIMER, periph_pkg::TMR_MTIME_LO, t0);
		n = $urandom_range(12, 4);
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP_LO, t0 + n);
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP_HI, '0);
		wait_cycles(1);
		check_true("irq high before mtimecmp was reached", !o_timer_irq);
		wait_irq(1'b1, (n + 2) * periph_pkg::CLK_MHZ, "irq did not rise in time");
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP_HI, '1);
		wait_irq(1'b0, 2, "irq did not fall after mtimecmp was raised");
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CMP_LO, '1);
		apb_write(periph_pkg::SLOT_TIMER, periph_pkg::TMR_CTRL, '0);
		end_test();

		start_test("serial");
		uart_div = $urandom_range(20, 4);
		apb_write(periph_pkg::SLOT_UART, periph_pkg::UART_DIV, 32'(uart_div));
		rx_q.delete();
		total_stalls = 0;
		n = periph_pkg::TXFIFO_DEPTH + $urandom_range(5, 2);
		repeat (n) begin
			wv = $urandom_range(255, 0);
			exp_q.push_back(periph_pkg::byte_t'(wv));
			apb_xfer(1'b1, periph_pkg::SLOT_UART, periph_pkg::UART_TXDATA, wv, rd, err, stalls);
			total_stalls += stalls;
		end
		check_true("no write stalled on a full FIFO", total_stalls > 0);
		stalls = 0;
		while (rx_q.size() < n) begin
			wait_cycles(1);
			stalls++;
			if (stalls > TIMEOUT) begin
				abort_run("serial frames did not arrive");
			end
		end
		foreach (exp_q[i]) begin
			check_value("received byte", {24'b0, exp_q[i]}, {24'b0, rx_q[i]});
		end
		// busy clears once the last stop bit is out
		stalls = 0;
		rd     = 32'd1;
		while (rd[0] && stalls < TIMEOUT) begin
			apb_read(periph_pkg::SLOT_UART, periph_pkg::UART_CSR, rd);
			stalls++;
		end
		check_value("csr after last frame", '0, rd);
		check_true("line not idle after last frame", o_uart_tx === 1'b1);
		// no stray frame behind the last written byte
		check_value("byte count", n, rx_q.size());
		end_test();

		$display("tests run %0d, tests failed %0d, failed checks %0d", tests_run,
			tests_failed, total_errs);
		if (total_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
hw/periph_pkg.sv
hw/apb_if.sv
hw/apb_decoder.sv
hw/mtimer.sv
hw/uart_tx.sv
hw/periph_top.sv
test/periph_assertions.sv
test/tb_periph.sv

/* run.sh */
#!/usr/bin/env bash
# Verilator build and run of tb_periph, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_periph \
	-f verilog.f -o sim_periph > build.log 2>&1 \
	&& ./obj_dir/sim_periph > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "^TB PASSED$" sim.log && exit 0 || exit 1
